// File: bg_geom_pkg.sv
package bg_geom_pkg;

    // Pixel coordinate, wide enough for rows below the visible area
    typedef logic [10:0] coord_t;

    typedef logic [1:0] colour_t;   // Per-channel intensity

    // Frame count from the vsync counter
    typedef logic [10:0] scroll_t;

    // 1024x768 timing
    localparam coord_t H_RES = 11'd1024;   // Also the horizontal wrap length
    localparam coord_t V_RES = 11'd768;

    // Base row of the ground line, just under the visible area
    localparam coord_t GROUND_Y = 11'd840;

    localparam colour_t WHITE = 2'd3;
    localparam colour_t BLACK = 2'd0;

endpackage

// File: bg_sprite_pkg.sv
package bg_sprite_pkg;

    // Mound placement along the ground
    localparam bg_geom_pkg::coord_t MOUND_X0     = 11'd306;
    localparam bg_geom_pkg::coord_t MOUND_W      = 11'd64;
    localparam bg_geom_pkg::coord_t HALF_MOUND_W = 11'd32;

    // Height of one half of the mound, mirrored for the other half
    function automatic logic [2:0] mound_height(input logic [4:0] idx);
        if (idx <= 5'd5)
            return 3'd0;
        else if (idx <= 5'd8)
            return 3'd1;
        else if (idx <= 5'd12)
            return 3'd2;
        else if (idx <= 5'd15)
            return 3'd3;
        else if (idx <= 5'd18)
            return 3'd4;
        else if (idx <= 5'd21)
            return 3'd5;
        else
            return 3'd6;   // Plateau
    endfunction

    // Three dot rows, each with its own period so the pattern looks irregular
    localparam bg_geom_pkg::coord_t DOT_PERIOD_A = 11'd8;
    localparam bg_geom_pkg::coord_t DOT_PHASE_A  = 11'd2;
    localparam bg_geom_pkg::coord_t DOT_ROW_A    = 11'd3;
    localparam bg_geom_pkg::coord_t DOT_PERIOD_B = 11'd11;
    localparam bg_geom_pkg::coord_t DOT_PHASE_B  = 11'd4;
    localparam bg_geom_pkg::coord_t DOT_ROW_B    = 11'd5;
    localparam bg_geom_pkg::coord_t DOT_PERIOD_C = 11'd17;
    localparam bg_geom_pkg::coord_t DOT_PHASE_C  = 11'd9;
    localparam bg_geom_pkg::coord_t DOT_ROW_C    = 11'd7;
    localparam bg_geom_pkg::coord_t DOT_DEPTH    = 11'd8;   // Band below the ground row

    // Cloud sprite, drawn at twice its bitmap size
    localparam bg_geom_pkg::coord_t CLOUD_W     = 11'd20;
    localparam bg_geom_pkg::coord_t CLOUD_H     = 11'd8;
    localparam bg_geom_pkg::coord_t CLOUD_SCALE = 11'd2;
    localparam bg_geom_pkg::coord_t CLOUD_BOX_W = CLOUD_W * CLOUD_SCALE;
    localparam bg_geom_pkg::coord_t CLOUD_BOX_H = CLOUD_H * CLOUD_SCALE;

    // MSB is sprite column 0
    function automatic logic [CLOUD_W-1:0] cloud_row(input bg_geom_pkg::coord_t row);
        case (row)
            11'd0:   return 20'b00000001111000000000;
            11'd1:   return 20'b00000111111100000000;
            11'd2:   return 20'b00011111111110000000;
            11'd3:   return 20'b00111111111111000000;
            11'd4:   return 20'b01111111111111100000;   // Widest row
            11'd5:   return 20'b00111111111111000000;
            11'd6:   return 20'b00011111111110000000;
            11'd7:   return 20'b00000111111100000000;
            default: return '0;
        endcase
    endfunction

    // Scene placement
    localparam bg_geom_pkg::coord_t CLOUD1_X_BASE = 11'd280;
    localparam bg_geom_pkg::coord_t CLOUD1_Y      = 11'd424;
    localparam bg_geom_pkg::coord_t CLOUD2_X_BASE = 11'd640;
    localparam bg_geom_pkg::coord_t CLOUD2_Y      = 11'd360;

endpackage

// File: mound_profile.sv
module mound_profile (
    input  bg_geom_pkg::coord_t  pix_x,
    input  bg_geom_pkg::scroll_t scroll,
    output bg_geom_pkg::coord_t  ground_row
);

    bg_geom_pkg::coord_t mound_sum;
    bg_geom_pkg::coord_t mound_col;
    bg_geom_pkg::coord_t mirror_col;
    logic                in_mound;
    logic [4:0]          mound_idx;
    logic [2:0]          height;

    // Column relative to the mound start, scrolled and wrapped to the screen width
    assign mound_sum = pix_x + scroll - bg_sprite_pkg::MOUND_X0;
    assign mound_col = mound_sum % bg_geom_pkg::H_RES;

    assign in_mound = (mound_col < bg_sprite_pkg::MOUND_W);

    // Right half walks the table backwards
    assign mirror_col = bg_sprite_pkg::MOUND_W - 11'd1 - mound_col;
    assign mound_idx  = (mound_col < bg_sprite_pkg::HALF_MOUND_W) ? mound_col[4:0]
                                                                  : mirror_col[4:0];

    assign height = bg_sprite_pkg::mound_height(mound_idx);

    // Raise the line by the mound height
    assign ground_row = in_mound ? (bg_geom_pkg::GROUND_Y - {8'd0, height})
                                 : bg_geom_pkg::GROUND_Y;

    // Line stays within the mound's reach of the base row
    always_comb
    begin
        assert final ((ground_row >= bg_geom_pkg::GROUND_Y - 11'd6) &&
                      (ground_row <= bg_geom_pkg::GROUND_Y))
            else $error("ground_row %0d outside mound range", ground_row);
    end

endmodule

// File: ground_painter.sv
module ground_painter (
    input  logic                 vsync,
    input  logic                 rst_n,
    input  bg_geom_pkg::coord_t  pix_x,
    input  bg_geom_pkg::coord_t  pix_y,
    output bg_geom_pkg::scroll_t scroll,
    output logic                 is_ground
);

    bg_geom_pkg::coord_t ground_row;
    bg_geom_pkg::coord_t scroll_col;
    bg_geom_pkg::coord_t rem_a;
    bg_geom_pkg::coord_t rem_b;
    bg_geom_pkg::coord_t rem_c;
    bg_geom_pkg::coord_t dot_dy;
    logic                is_line;
    logic                in_band;
    logic                dot_a;
    logic                dot_b;
    logic                dot_c;

    // One step per frame
    always_ff @(posedge vsync or negedge rst_n)
    begin
        if (!rst_n)
            scroll <= '0;
        else
            scroll <= scroll + 11'd1;   // Wraps after 2048 frames
    end

    mound_profile mound0 (
        .pix_x      (pix_x),
        .scroll     (scroll),
        .ground_row (ground_row)
    );

    assign is_line = (pix_y == ground_row);

    // Dots scroll with the ground
    assign scroll_col = pix_x + scroll;

    assign rem_a = scroll_col % bg_sprite_pkg::DOT_PERIOD_A;
    assign rem_b = scroll_col % bg_sprite_pkg::DOT_PERIOD_B;
    assign rem_c = scroll_col % bg_sprite_pkg::DOT_PERIOD_C;

    // Row offset below the line, only meaningful inside the band
    assign dot_dy  = pix_y - ground_row;
    assign in_band = (pix_y > ground_row) && (dot_dy <= bg_sprite_pkg::DOT_DEPTH);

    assign dot_a = (dot_dy == bg_sprite_pkg::DOT_ROW_A) &&
                   (rem_a == bg_sprite_pkg::DOT_PHASE_A);
    assign dot_b = (dot_dy == bg_sprite_pkg::DOT_ROW_B) &&
                   (rem_b == bg_sprite_pkg::DOT_PHASE_B);
    assign dot_c = (dot_dy == bg_sprite_pkg::DOT_ROW_C) &&
                   (rem_c == bg_sprite_pkg::DOT_PHASE_C);

    assign is_ground = is_line || (in_band && (dot_a || dot_b || dot_c));

    // Nothing of the ground ever shows above the line for this column
    a_ground_below_line: assert property (
        @(posedge vsync) disable iff (!rst_n)
        is_ground |-> (pix_y >= ground_row)
    ) else $error("ground pixel above line at x=%0d y=%0d", pix_x, pix_y);

endmodule

// File: cloud_sprite.sv
module cloud_sprite #(
    parameter bg_geom_pkg::coord_t X_BASE = 11'd0,
    parameter bg_geom_pkg::coord_t Y_TOP  = 11'd0
) (
    input  bg_geom_pkg::coord_t  pix_x,
    input  bg_geom_pkg::coord_t  pix_y,
    input  bg_geom_pkg::scroll_t scroll,
    output logic                 hit
);

    bg_geom_pkg::coord_t          left_sum;
    bg_geom_pkg::coord_t          left_x;
    bg_geom_pkg::coord_t          local_x;
    bg_geom_pkg::coord_t          local_y;
    bg_geom_pkg::coord_t          sprite_col;
    bg_geom_pkg::coord_t          sprite_row;
    logic [bg_sprite_pkg::CLOUD_W-1:0] row_bits;
    logic [4:0]                   bit_sel;
    logic                         in_box;

    // Drifts left at half the ground speed
    assign left_sum = X_BASE + bg_geom_pkg::H_RES - (scroll >> 1);
    assign left_x   = left_sum % bg_geom_pkg::H_RES;

    assign in_box = (pix_x >= left_x) &&
                    (pix_x < left_x + bg_sprite_pkg::CLOUD_BOX_W) &&
                    (pix_y >= Y_TOP) &&
                    (pix_y < Y_TOP + bg_sprite_pkg::CLOUD_BOX_H);

    assign local_x = pix_x - left_x;
    assign local_y = pix_y - Y_TOP;

    // Back to bitmap resolution
    assign sprite_col = local_x / bg_sprite_pkg::CLOUD_SCALE;
    assign sprite_row = local_y / bg_sprite_pkg::CLOUD_SCALE;

    assign row_bits = bg_sprite_pkg::cloud_row(sprite_row);
    assign bit_sel  = 5'(bg_sprite_pkg::CLOUD_W - 11'd1 - sprite_col);   // Column 0 is the MSB

    assign hit = in_box ? row_bits[bit_sel] : 1'b0;

    always_comb
    begin
        if (in_box)
        begin
            assert final ((sprite_col < bg_sprite_pkg::CLOUD_W) &&
                          (sprite_row < bg_sprite_pkg::CLOUD_H))
                else $error("cloud lookup off bitmap col=%0d row=%0d",
                            sprite_col, sprite_row);
        end
    end

endmodule

// File: cloud_painter.sv
module cloud_painter (
    input  bg_geom_pkg::coord_t  pix_x,
    input  bg_geom_pkg::coord_t  pix_y,
    input  bg_geom_pkg::scroll_t scroll,
    output logic                 is_cloud
);

    logic hit1;
    logic hit2;
    logic in_rows1;
    logic in_rows2;

    cloud_sprite #(
        .X_BASE (bg_sprite_pkg::CLOUD1_X_BASE),
        .Y_TOP  (bg_sprite_pkg::CLOUD1_Y)
    ) cloud1 (
        .pix_x  (pix_x),
        .pix_y  (pix_y),
        .scroll (scroll),
        .hit    (hit1)
    );

    cloud_sprite #(
        .X_BASE (bg_sprite_pkg::CLOUD2_X_BASE),
        .Y_TOP  (bg_sprite_pkg::CLOUD2_Y)
    ) cloud2 (
        .pix_x  (pix_x),
        .pix_y  (pix_y),
        .scroll (scroll),
        .hit    (hit2)
    );

    assign is_cloud = hit1 || hit2;

    // Clouds only move sideways, so their rows never change with scroll
    assign in_rows1 = (pix_y >= bg_sprite_pkg::CLOUD1_Y) &&
                      (pix_y < bg_sprite_pkg::CLOUD1_Y + bg_sprite_pkg::CLOUD_BOX_H);
    assign in_rows2 = (pix_y >= bg_sprite_pkg::CLOUD2_Y) &&
                      (pix_y < bg_sprite_pkg::CLOUD2_Y + bg_sprite_pkg::CLOUD_BOX_H);

    always_comb
    begin
        assert final (!is_cloud || in_rows1 || in_rows2)
            else $error("cloud pixel on row %0d outside both cloud bands", pix_y);
    end

endmodule

// File: bg_mixer.sv
module bg_mixer (
    input  logic                 video_active,
    input  logic                 bg_en,
    input  logic                 is_ground,
    input  logic                 is_cloud,
    output bg_geom_pkg::colour_t r,
    output bg_geom_pkg::colour_t g,
    output bg_geom_pkg::colour_t b
);

    logic                 show;
    bg_geom_pkg::colour_t level;

    // Blanking wins over everything
    assign show  = video_active && bg_en && (is_ground || is_cloud);
    assign level = show ? bg_geom_pkg::WHITE : bg_geom_pkg::BLACK;

    // Monochrome scene
    assign r = level;
    assign g = level;
    assign b = level;

    always_comb
    begin
        if (!video_active)
        begin
            assert final ((r == bg_geom_pkg::BLACK) && (g == bg_geom_pkg::BLACK) &&
                          (b == bg_geom_pkg::BLACK))
                else $error("colour driven during blanking");
        end
    end

endmodule

// File: bg_pixel_dunes.sv
module bg_pixel_dunes (
    input  logic                 vsync,
    input  logic                 rst_n,
    input  logic                 bg_en,
    input  logic                 video_active,
    input  bg_geom_pkg::coord_t  pix_x,
    input  bg_geom_pkg::coord_t  pix_y,
    output bg_geom_pkg::colour_t r,
    output bg_geom_pkg::colour_t g,
    output bg_geom_pkg::colour_t b
);

    bg_geom_pkg::scroll_t scroll;
    logic                 is_ground;
    logic                 is_cloud;

    // Owns the frame counter
    ground_painter ground0 (
        .vsync     (vsync),
        .rst_n     (rst_n),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .scroll    (scroll),
        .is_ground (is_ground)
    );

    cloud_painter clouds0 (
        .pix_x    (pix_x),
        .pix_y    (pix_y),
        .scroll   (scroll),
        .is_cloud (is_cloud)
    );

    bg_mixer mixer0 (
        .video_active (video_active),
        .bg_en        (bg_en),
        .is_ground    (is_ground),
        .is_cloud     (is_cloud),
        .r            (r),
        .g            (g),
        .b            (b)
    );

endmodule

// File: tb_bg_pixel_dunes.sv
module tb_bg_pixel_dunes;

    logic                 vsync;
    logic                 rst_n;
    logic                 bg_en;
    logic                 video_active;
    bg_geom_pkg::coord_t  pix_x;
    bg_geom_pkg::coord_t  pix_y;
    bg_geom_pkg::colour_t r;
    bg_geom_pkg::colour_t g;
    bg_geom_pkg::colour_t b;

    bg_geom_pkg::scroll_t frame;        // Reference copy of the scroll position
    bg_geom_pkg::colour_t exp_level;
    int unsigned          lcg_state = 32'd14;
    int                   line_hits;
    int                   dot_hits;
    int                   cloud_hits;

    bg_pixel_dunes dut0 (
        .vsync        (vsync),
        .rst_n        (rst_n),
        .bg_en        (bg_en),
        .video_active (video_active),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .r            (r),
        .g            (g),
        .b            (b)
    );

    initial
    begin
        vsync = 1'b0;
        forever #5 vsync = ~vsync;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;   // Low bits of an LCG cycle too quickly
    endfunction

    function automatic int rand_below(input int n);
        return int'(lcg_next() % $unsigned(n));
    endfunction

    function automatic int wrap_mod(input int v, input int m);
        int q;
        q = v % m;
        if (q < 0)
            q = q + m;
        return q;
    endfunction

    // One step up at each threshold of the half-mound table
    function automatic int expected_height(input int idx);
        int h;
        h = 0;
        if (idx >= 6)
            h++;
        if (idx >= 9)
            h++;
        if (idx >= 13)
            h++;
        if (idx >= 16)
            h++;
        if (idx >= 19)
            h++;
        if (idx >= 22)
            h++;
        return h;
    endfunction

    function automatic int mound_col_of(input int x, input int s);
        return wrap_mod(x + s - int'(bg_sprite_pkg::MOUND_X0), int'(bg_geom_pkg::H_RES));
    endfunction

    // Screen column that lands on mound column c at scroll s
    function automatic int x_for_mound_col(input int c, input int s);
        return wrap_mod(c + int'(bg_sprite_pkg::MOUND_X0) - s, int'(bg_geom_pkg::H_RES));
    endfunction

    function automatic int ground_row_of(input int x, input int s);
        int mc;
        int idx;
        mc = mound_col_of(x, s);
        if (mc >= int'(bg_sprite_pkg::MOUND_W))
            return int'(bg_geom_pkg::GROUND_Y);
        idx = (mc < int'(bg_sprite_pkg::HALF_MOUND_W)) ? mc
                                                        : int'(bg_sprite_pkg::MOUND_W) - 1 - mc;
        return int'(bg_geom_pkg::GROUND_Y) - expected_height(idx);
    endfunction

    function automatic bit ground_pixel(input int x, input int y, input int s);
        int dy;
        int sc;
        dy = y - ground_row_of(x, s);
        sc = (x + s) % 2048;
        return (dy == 0) ||
               ((dy == int'(bg_sprite_pkg::DOT_ROW_A)) &&
                (sc % int'(bg_sprite_pkg::DOT_PERIOD_A) == int'(bg_sprite_pkg::DOT_PHASE_A))) ||
               ((dy == int'(bg_sprite_pkg::DOT_ROW_B)) &&
                (sc % int'(bg_sprite_pkg::DOT_PERIOD_B) == int'(bg_sprite_pkg::DOT_PHASE_B))) ||
               ((dy == int'(bg_sprite_pkg::DOT_ROW_C)) &&
                (sc % int'(bg_sprite_pkg::DOT_PERIOD_C) == int'(bg_sprite_pkg::DOT_PHASE_C)));
    endfunction

    function automatic int cloud_left(input int x_base, input int s);
        return (x_base + int'(bg_geom_pkg::H_RES) - s / 2) % int'(bg_geom_pkg::H_RES);
    endfunction

    function automatic bit cloud_pixel(input int x, input int y, input int s,
                                       input int x_base, input int y_top);
        logic [bg_sprite_pkg::CLOUD_W-1:0] bits;
        int left;
        int col;
        int row;
        left = cloud_left(x_base, s);
        if ((x < left) || (x >= left + int'(bg_sprite_pkg::CLOUD_BOX_W)) ||
            (y < y_top) || (y >= y_top + int'(bg_sprite_pkg::CLOUD_BOX_H)))
            return 1'b0;
        col  = (x - left) / int'(bg_sprite_pkg::CLOUD_SCALE);
        row  = (y - y_top) / int'(bg_sprite_pkg::CLOUD_SCALE);
        bits = bg_sprite_pkg::cloud_row(bg_geom_pkg::coord_t'(row));
        return bits[5'(int'(bg_sprite_pkg::CLOUD_W) - 1 - col)];   // Column 0 on the left
    endfunction

    function automatic bit any_cloud(input int x, input int y, input int s);
        return cloud_pixel(x, y, s, int'(bg_sprite_pkg::CLOUD1_X_BASE),
                           int'(bg_sprite_pkg::CLOUD1_Y)) ||
               cloud_pixel(x, y, s, int'(bg_sprite_pkg::CLOUD2_X_BASE),
                           int'(bg_sprite_pkg::CLOUD2_Y));
    endfunction

    always_ff @(posedge vsync or negedge rst_n)
    begin
        if (!rst_n)
            frame <= '0;
        else
            frame <= frame + 11'd1;
    end

    always_comb
    begin
        if (video_active && bg_en &&
            (ground_pixel(int'(pix_x), int'(pix_y), int'(frame)) ||
             any_cloud(int'(pix_x), int'(pix_y), int'(frame))))
            exp_level = bg_geom_pkg::WHITE;
        else
            exp_level = bg_geom_pkg::BLACK;
    end

    a_pixel_match: assert property (@(posedge vsync) disable iff (!rst_n)
        (r == exp_level) && (g == exp_level) && (b == exp_level))
    else
    begin
        $display("** Error at %0t: wrong colour at pixel (%0d,%0d)", $time, pix_x, pix_y);
        $display("SOME TESTS FAILED");
        $fatal(1, "pixel colour mismatch");
    end

    a_blanked: assert property (@(posedge vsync) disable iff (!rst_n)
        !video_active |-> ((r == bg_geom_pkg::BLACK) && (g == bg_geom_pkg::BLACK) &&
                           (b == bg_geom_pkg::BLACK)))
    else
    begin
        $display("** Error at %0t: colour during blanking at (%0d,%0d)", $time, pix_x, pix_y);
        $display("SOME TESTS FAILED");
        $fatal(1, "blanking not black");
    end

    a_disabled: assert property (@(posedge vsync) disable iff (!rst_n)
        !bg_en |-> ((r == bg_geom_pkg::BLACK) && (g == bg_geom_pkg::BLACK) &&
                    (b == bg_geom_pkg::BLACK)))
    else
    begin
        $display("** Error at %0t: colour with bg_en low at (%0d,%0d)", $time, pix_x, pix_y);
        $display("SOME TESTS FAILED");
        $fatal(1, "disabled background not black");
    end

    task automatic step_frame();
        @(posedge vsync);
        #1;
    endtask

    // Holds one pixel for one frame, checked at the next vsync edge
    task automatic apply_pixel(input int x, input int y, input bit va, input bit en);
        int s;
        s = int'(frame);
        pix_x        = bg_geom_pkg::coord_t'(x);
        pix_y        = bg_geom_pkg::coord_t'(y);
        video_active = va;
        bg_en        = en;
        if (va && en)
        begin
            if (y == ground_row_of(x, s))
                line_hits++;
            else if (ground_pixel(x, y, s))
                dot_hits++;
            if (any_cloud(x, y, s))
                cloud_hits++;
        end
        step_frame();
    endtask

    task automatic random_pixel();
        int choice;
        int left;
        choice = rand_below(4);
        if (choice == 0)
            apply_pixel(rand_below(1024), int'(bg_geom_pkg::GROUND_Y) - 10 + rand_below(22),
                        rand_below(8) != 0, rand_below(8) != 0);
        else if (choice == 1)
        begin
            left = cloud_left(int'(bg_sprite_pkg::CLOUD1_X_BASE), int'(frame));
            apply_pixel(left + rand_below(44), int'(bg_sprite_pkg::CLOUD1_Y) - 2 + rand_below(20),
                        rand_below(8) != 0, rand_below(8) != 0);
        end
        else if (choice == 2)
        begin
            left = cloud_left(int'(bg_sprite_pkg::CLOUD2_X_BASE), int'(frame));
            apply_pixel(left + rand_below(44), int'(bg_sprite_pkg::CLOUD2_Y) - 2 + rand_below(20),
                        rand_below(8) != 0, rand_below(8) != 0);
        end
        else
            apply_pixel(rand_below(1024), rand_below(1024), rand_below(8) != 0, 1'b1);
    endtask

    task automatic run_random_until(input int target, input int limit);
        int spins;
        spins = 0;
        while ((int'(frame) != target) && (spins < limit))
        begin
            random_pixel();
            spins++;
        end
        if (int'(frame) != target)
        begin
            $display("SOME TESTS FAILED");
            $fatal(1, "Timed out waiting for the frame count to reach %0d", target);
        end
    endtask

    // A fixed column sees the mound slide past one column per frame
    task automatic sweep_mound();
        int x;
        int k;
        int i;
        for (k = 0; k < 7; k++)
        begin
            x = x_for_mound_col(0, int'(frame));
            for (i = 0; i < 64; i++)
                apply_pixel(x, int'(bg_geom_pkg::GROUND_Y) - 6 + k, 1'b1, 1'b1);
        end
    endtask

    task automatic check_blanking();
        int i;
        int x;
        int y;
        int mode;
        for (i = 0; i < 48; i++)
        begin
            if (i % 2 == 0)
            begin
                x = x_for_mound_col(64 + rand_below(900), int'(frame));
                y = int'(bg_geom_pkg::GROUND_Y);
            end
            else
            begin
                x = cloud_left(int'(bg_sprite_pkg::CLOUD1_X_BASE), int'(frame)) + 19;
                y = int'(bg_sprite_pkg::CLOUD1_Y) + 8;   // Widest sprite row
            end
            mode = (i / 2) % 4;   // Every va/en pair on both targets
            apply_pixel(x, y, mode == 1 || mode == 3, mode == 0 || mode == 3);
        end
    endtask

    initial
    begin
        int i;
        int x;
        int left;
        rst_n        = 1'b0;
        bg_en        = 1'b0;
        video_active = 1'b0;
        pix_x        = '0;
        pix_y        = '0;
        line_hits    = 0;
        dot_hits     = 0;
        cloud_hits   = 0;
        for (i = 0; i < 8; i++)
            step_frame();
        rst_n = 1'b1;
        apply_pixel(2, int'(bg_geom_pkg::GROUND_Y) + 3, 1'b1, 1'b1);   // Dot only at scroll 0
        check_blanking();
        for (i = 0; i < 60; i++)
            apply_pixel(x_for_mound_col(64 + rand_below(960), int'(frame)),
                        int'(bg_geom_pkg::GROUND_Y) - 1 + rand_below(3), 1'b1, 1'b1);
        sweep_mound();
        for (i = 0; i < 320; i++)
        begin
            x = rand_below(1024);
            apply_pixel(x, ground_row_of(x, int'(frame)) + 1 + rand_below(8), 1'b1, 1'b1);
        end
        for (i = 0; i < 400; i++)
        begin
            if (i % 2 == 0)
            begin
                left = cloud_left(int'(bg_sprite_pkg::CLOUD1_X_BASE), int'(frame));
                x    = left - 4 + rand_below(48);
                apply_pixel((x < 0) ? 0 : x,
                            int'(bg_sprite_pkg::CLOUD1_Y) - 2 + rand_below(20), 1'b1, 1'b1);
            end
            else
            begin
                left = cloud_left(int'(bg_sprite_pkg::CLOUD2_X_BASE), int'(frame));
                x    = left - 4 + rand_below(48);
                apply_pixel((x < 0) ? 0 : x,
                            int'(bg_sprite_pkg::CLOUD2_Y) - 2 + rand_below(20), 1'b1, 1'b1);
            end
        end
        run_random_until(0, 2200);   // Scroll wraps after 2048 frames
        apply_pixel(2, int'(bg_geom_pkg::GROUND_Y) + 3, 1'b1, 1'b1);
        sweep_mound();
        if ((line_hits == 0) || (dot_hits == 0) || (cloud_hits == 0))
        begin
            $display("SOME TESTS FAILED");
            $fatal(1, "Stimulus never reached a ground line, dot or cloud pixel");
        end
        else
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: tb.f
bg_geom_pkg.sv
bg_sprite_pkg.sv
mound_profile.sv
ground_painter.sv
cloud_sprite.sv
cloud_painter.sv
bg_mixer.sv
bg_pixel_dunes.sv
tb_bg_pixel_dunes.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_bg_pixel_dunes -f tb.f -o tb_sim &&
./obj_dir/tb_sim || { echo "simulation failed"; exit 1; }
